/* tb.f */
+incdir+include
verilog/lq_pkg.sv
verilog/lq_issue_if.sv
verilog/lq_alloc.sv
verilog/lq_entries.sv
verilog/lq_select.sv
verilog/lq_ctrl.sv
verilog/lq_load_data.sv
verilog/load_queue.sv
sim/load_queue_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the load queue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary -j 0 -f tb.f --top-module load_queue_tb -o load_queue_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/load_queue_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* sim/load_queue_tb.sv */
`timescale 1ns/1ps
`include "lq_settings.svh"

module load_queue_tb;
    import lq_pkg::*;

    typedef enum logic [2:0] {
        OP_ALLOC, OP_UPD, OP_CMMT, OP_FLSH, OP_ISSUE, OP_QUIET, OP_STLL
    } op_e;

    typedef struct packed {
        op_e op;
        logic [2:0] lanes;
        lq_tag_t tag;
        lq_addr_t addr;
        lq_preg_t preg;
        lq_ptr_t ptr;
        logic flag;        // fwd on issue rows, expected stll on stall rows
        lq_data_t dca;
        lq_data_t dsq;
    } row_t;

    localparam int WAIT_LIMIT = 50;
    localparam int QUIET_CYCLES = 20;

    logic clk;
    logic rst;
    logic [`LQ_LANES-1:0] alloc_vld;
    lq_tag_t [`LQ_LANES-1:0] alloc_tag;
    logic flsh;
    lq_ptr_t mis_pred_ptr;
    logic mem_rd;
    logic [`LQ_TAG_W-2:0] upd_tag;
    lq_addr_t upd_addr;
    lq_preg_t upd_preg;
    lq_ptr_t cmmt_ptr;
    logic ld_grnt;
    logic done;
    logic fwd_rdy;
    logic fwd;
    lq_data_t data_ca;
    lq_data_t data_sq;
    logic ld_req;
    logic ld_vld;
    logic stll;
    lq_data_t data_ld;
    lq_addr_t addr;
    lq_preg_t phy_addr_ld;
    lq_tag_t indx_fwd;

    row_t rows[$];
    int checks = 0;
    int errors = 0;
    int timeouts = 0;

    load_queue load_queue_inst (.*);

    always #5 clk = ~clk;

    task automatic check_addr(input lq_addr_t got, input lq_addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input lq_data_t got, input lq_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_preg(input lq_preg_t got, input lq_preg_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_tag(input lq_tag_t got, input lq_tag_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input op_e op, input int lanes, input lq_tag_t tag,
                           input lq_addr_t a, input lq_preg_t p, input lq_ptr_t ptr,
                           input logic flag);
        row_t r;
        r.op = op;
        r.lanes = 3'(lanes);
        r.tag = tag;
        r.addr = a;
        r.preg = p;
        r.ptr = ptr;
        r.flag = flag;
        r.dca = lq_data_t'($urandom);
        r.dsq = lq_data_t'($urandom);
        rows.push_back(r);
    endtask

    task automatic build_table();
        // four loads, addresses reported youngest first
        add_row(OP_ALLOC, 4, 7'h10, '0, '0, '0, 1'b0);
        for (int k = 3; k >= 0; k--)
            add_row(OP_UPD, 0, lq_tag_t'(7'h10 + k), lq_addr_t'(16'h1000 + 16'h100 * k),
                    lq_preg_t'(10 + k), '0, 1'b0);
        for (int k = 0; k < 4; k++)
            add_row(OP_ISSUE, 0, lq_tag_t'(7'h10 + k), lq_addr_t'(16'h1000 + 16'h100 * k),
                    lq_preg_t'(10 + k), '0, 1'b0);
        // store queue forwarding, entries 4 and 5
        add_row(OP_ALLOC, 2, 7'h14, '0, '0, '0, 1'b0);
        add_row(OP_UPD, 0, 7'h14, 16'h2400, 6'd20, '0, 1'b0);
        add_row(OP_UPD, 0, 7'h15, 16'h2500, 6'd21, '0, 1'b0);
        add_row(OP_ISSUE, 0, 7'h14, 16'h2400, 6'd20, '0, 1'b1);
        add_row(OP_ISSUE, 0, 7'h15, 16'h2500, 6'd21, '0, 1'b0);
        add_row(OP_CMMT, 0, '0, '0, '0, 5'd6, 1'b0);
        // fill all 24 entries, tail comes back to the head
        for (int k = 0; k < 6; k++)
            add_row(OP_ALLOC, 4, lq_tag_t'(7'h20 + 4 * k), '0, '0, '0, 1'b0);
        add_row(OP_STLL, 0, '0, '0, '0, '0, 1'b1);
        add_row(OP_CMMT, 0, '0, '0, '0, 5'd10, 1'b0);
        add_row(OP_STLL, 0, '0, '0, '0, '0, 1'b0);
        // drain, then flush the two youngest of four
        add_row(OP_CMMT, 0, '0, '0, '0, 5'd6, 1'b0);
        add_row(OP_ALLOC, 4, 7'h50, '0, '0, '0, 1'b0);
        add_row(OP_FLSH, 0, '0, '0, '0, 5'd8, 1'b0);
        add_row(OP_UPD, 0, 7'h52, 16'h5200, 6'd32, '0, 1'b0);
        add_row(OP_UPD, 0, 7'h53, 16'h5300, 6'd33, '0, 1'b0);
        add_row(OP_QUIET, 0, '0, '0, '0, '0, 1'b0);
        add_row(OP_UPD, 0, 7'h51, 16'h5100, 6'd31, '0, 1'b0);
        add_row(OP_ISSUE, 0, 7'h51, 16'h5100, 6'd31, '0, 1'b0);
        add_row(OP_QUIET, 0, '0, '0, '0, '0, 1'b0);
    endtask

    task automatic wait_req(output logic seen);
        int n;
        n = 0;
        while (!ld_req && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        seen = ld_req;
        if (!seen) begin
            timeouts++;
            $display("timeout at %0t: no load request after %0d cycles", $time, WAIT_LIMIT);
        end
    endtask

    task automatic wait_vld(output logic seen);
        int n;
        n = 0;
        while (!ld_vld && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        seen = ld_vld;
        if (!seen) begin
            timeouts++;
            $display("timeout at %0t: load never wrote back after %0d cycles", $time, WAIT_LIMIT);
        end
    endtask

    task automatic drive_strobes(input logic cache, input logic store, input row_t r);
        done = cache;
        data_ca = cache ? r.dca : '0;
        fwd_rdy = store;
        fwd = store ? r.flag : 1'b0;
        data_sq = store ? r.dsq : '0;
    endtask

    // memory side: grant, then cache and store queue answers in random order
    task automatic serve_load(input row_t r);
        logic seen;
        int order;
        wait_req(seen);
        if (seen) begin
            repeat ($urandom_range(0, 3)) @(negedge clk);
            ld_grnt = 1'b1;
            @(negedge clk);
            ld_grnt = 1'b0;
            repeat ($urandom_range(0, 2)) @(negedge clk);
            order = $urandom_range(0, 2);   // 0 cache first, 1 store first, 2 together
            drive_strobes(order != 1, order != 0, r);
            @(negedge clk);
            drive_strobes(order == 1, order == 0, r);
            @(negedge clk);
            drive_strobes(1'b0, 1'b0, r);
            wait_vld(seen);
            if (seen) begin
                check_addr(addr, r.addr, "addr");
                check_preg(phy_addr_ld, r.preg, "phy_addr_ld");
                check_tag(indx_fwd, r.tag, "indx_fwd");
                check_data(data_ld, r.flag ? r.dsq : r.dca, "data_ld");
                @(negedge clk);
                check_bit(ld_vld, 1'b0, "ld_vld after writeback");
            end
        end
    endtask

    task automatic expect_quiet();
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            check_bit(ld_req, 1'b0, "ld_req with nothing ready");
        end
    endtask

    task automatic apply_row(input row_t r);
        case (r.op)
            OP_ALLOC: begin
                check_bit(stll, 1'b0, "stll before allocate");
                for (int l = 0; l < `LQ_LANES; l++) begin
                    alloc_vld[l] = (l < r.lanes);
                    alloc_tag[l] = r.tag + lq_tag_t'(l);
                end
                @(negedge clk);
                alloc_vld = '0;
            end
            OP_UPD: begin
                mem_rd = 1'b1;
                upd_tag = r.tag[`LQ_TAG_W-2:0];
                upd_addr = r.addr;
                upd_preg = r.preg;
                @(negedge clk);
                mem_rd = 1'b0;
            end
            OP_CMMT: begin
                cmmt_ptr = r.ptr;   // level, head follows it
                @(negedge clk);
            end
            OP_FLSH: begin
                flsh = 1'b1;
                mis_pred_ptr = r.ptr;
                @(negedge clk);
                flsh = 1'b0;
            end
            OP_ISSUE: serve_load(r);
            OP_QUIET: expect_quiet();
            OP_STLL: check_bit(stll, r.flag, "stll");
            default: ;
        endcase
    endtask

    initial begin
        void'($urandom(62));
        clk = 1'b0;
        rst = 1'b0;
        alloc_vld = '0;
        alloc_tag = '0;
        flsh = 1'b0;
        mis_pred_ptr = '0;
        mem_rd = 1'b0;
        upd_tag = '0;
        upd_addr = '0;
        upd_preg = '0;
        cmmt_ptr = '0;
        ld_grnt = 1'b0;
        drive_strobes(1'b0, 1'b0, '0);
        build_table();
        repeat (2) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_bit(stll, 1'b0, "stll after reset");
        check_bit(ld_req, 1'b0, "ld_req after reset");
        check_bit(ld_vld, 1'b0, "ld_vld after reset");
        foreach (rows[i])
            apply_row(rows[i]);
        repeat (2) @(negedge clk);
        $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* verilog/load_queue.sv */
`timescale 1ns/1ps
`include "lq_settings.svh"

module load_queue (
    input logic clk,
    input logic rst,
    input logic [`LQ_LANES-1:0] alloc_vld,
    input lq_pkg::lq_tag_t [`LQ_LANES-1:0] alloc_tag,
    input logic flsh,
    input lq_pkg::lq_ptr_t mis_pred_ptr,
    input logic mem_rd,
    input logic [`LQ_TAG_W-2:0] upd_tag,
    input lq_pkg::lq_addr_t upd_addr,
    input lq_pkg::lq_preg_t upd_preg,
    input lq_pkg::lq_ptr_t cmmt_ptr,
    input logic ld_grnt,
    input logic done,
    input logic fwd_rdy,
    input logic fwd,
    input lq_pkg::lq_data_t data_ca,
    input lq_pkg::lq_data_t data_sq,
    output logic ld_req,
    output logic ld_vld,
    output logic stll,
    output lq_pkg::lq_data_t data_ld,
    output lq_pkg::lq_addr_t addr,
    output lq_pkg::lq_preg_t phy_addr_ld,
    output lq_pkg::lq_tag_t indx_fwd
);
    import lq_pkg::*;

    lq_ptr_t tail;
    lq_ptr_t head;
    lq_mask_t insert;
    lq_tag_t [`LQ_DEPTH-1:0] insert_tag;
    logic tail_free;
    lq_entry_t cur_entry;

    lq_issue_if issue ();

    lq_alloc alloc_inst (
        .clk(clk), .rst(rst),
        .alloc_vld(alloc_vld), .alloc_tag(alloc_tag),
        .flsh(flsh), .mis_pred_ptr(mis_pred_ptr),
        .tail_free(tail_free), .tail(tail),
        .insert(insert), .insert_tag(insert_tag),
        .stll(stll)
    );

    lq_entries entries_inst (
        .clk(clk), .rst(rst),
        .insert(insert), .insert_tag(insert_tag),
        .mem_rd(mem_rd), .upd_tag(upd_tag), .upd_addr(upd_addr), .upd_preg(upd_preg),
        .cmmt_ptr(cmmt_ptr), .flsh(flsh), .mis_pred_ptr(mis_pred_ptr), .tail(tail),
        .issue(issue.entries),
        .head(head), .tail_free(tail_free), .cur_entry(cur_entry)
    );

    lq_select select_inst (
        .clk(clk), .rst(rst),
        .head(head),
        .issue(issue.select)
    );

    lq_ctrl ctrl_inst (
        .clk(clk), .rst(rst),
        .ld_grnt(ld_grnt), .done(done), .fwd_rdy(fwd_rdy),
        .issue(issue.ctrl),
        .ld_req(ld_req), .ld_vld(ld_vld)
    );

    lq_load_data load_data_inst (
        .clk(clk), .rst(rst),
        .done(done), .fwd_rdy(fwd_rdy), .fwd(fwd),
        .wb_vld(ld_vld),
        .data_ca(data_ca), .data_sq(data_sq),
        .data_ld(data_ld)
    );

    // fields of the load being issued
    assign addr = cur_entry.addr;
    assign phy_addr_ld = cur_entry.preg;
    assign indx_fwd = cur_entry.tag;

endmodule

/* verilog/lq_load_data.sv */
`timescale 1ns/1ps

module lq_load_data (
    input logic clk,
    input logic rst,
    input logic done,
    input logic fwd_rdy,
    input logic fwd,
    input logic wb_vld,
    input lq_pkg::lq_data_t data_ca,
    input lq_pkg::lq_data_t data_sq,
    output lq_pkg::lq_data_t data_ld
);
    import lq_pkg::*;

    logic stored_fwd;
    lq_data_t stored_ca;
    lq_data_t stored_sq;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            stored_fwd <= 1'b0;
        else if (fwd_rdy)
            stored_fwd <= fwd;   // store queue owns the bytes
    end

    always_ff @(posedge clk) begin
        if (done)
            stored_ca <= data_ca;
        if (fwd_rdy)
            stored_sq <= data_sq;
    end

    // result bus only carries data during the writeback strobe
    assign data_ld = !wb_vld ? '0 : (stored_fwd ? stored_sq : stored_ca);

endmodule

/* verilog/lq_ctrl.sv */
`timescale 1ns/1ps

module lq_ctrl (
    input logic clk,
    input logic rst,
    input logic ld_grnt,
    input logic done,
    input logic fwd_rdy,
    lq_issue_if.ctrl issue,
    output logic ld_req,
    output logic ld_vld
);
    import lq_pkg::*;

    lq_state_e state;
    lq_state_e nxt_state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            state <= IDLE;
        else
            state <= nxt_state;
    end

    always_comb begin
        nxt_state = state;
        ld_req = 1'b0;
        ld_vld = 1'b0;
        issue.busy = 1'b0;
        issue.finished = 1'b0;
        case (state)
            IDLE: begin
                if (issue.ld_rdy)
                    nxt_state = WAIT;
            end
            WAIT: begin
                ld_req = 1'b1;   // held until granted
                if (ld_grnt)
                    nxt_state = ISSUED;
            end
            ISSUED: begin
                issue.busy = 1'b1;
                if (done && fwd_rdy)
                    nxt_state = BOTH_RDY;
                else if (done)
                    nxt_state = MEM_RDY;
                else if (fwd_rdy)
                    nxt_state = FWD_RDY;
            end
            MEM_RDY: begin
                issue.busy = 1'b1;
                if (fwd_rdy)
                    nxt_state = WRITEBACK;
            end
            FWD_RDY: begin
                issue.busy = 1'b1;
                if (done)
                    nxt_state = WRITEBACK;
            end
            BOTH_RDY: begin
                issue.busy = 1'b1;
                nxt_state = WRITEBACK;
            end
            WRITEBACK: begin
                issue.busy = 1'b1;
                issue.finished = 1'b1;
                ld_vld = 1'b1;
                nxt_state = IDLE;
            end
            default: nxt_state = IDLE;
        endcase
    end

endmodule

/* verilog/lq_select.sv */
`timescale 1ns/1ps
`include "lq_settings.svh"

module lq_select (
    input logic clk,
    input logic rst,
    input lq_pkg::lq_ptr_t head,
    lq_issue_if.select issue
);
    import lq_pkg::*;

    lq_mask_t rot;     // ready_mask with head at bit 0
    lq_ptr_t offs;     // age of the oldest ready entry
    lq_ptr_t pick;

    always_comb begin
        for (int i = 0; i < `LQ_DEPTH; i++)
            rot[i] = issue.ready_mask[lq_wrap_add(head, lq_ptr_t'(i))];
    end

    // lowest set bit wins, i.e. closest to head
    always_comb begin
        offs = '0;
        for (int i = `LQ_DEPTH - 1; i >= 0; i--) begin
            if (rot[i])
                offs = lq_ptr_t'(i);
        end
    end

    assign pick = lq_wrap_add(head, offs);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            issue.current <= '0;
        else if (!issue.busy)
            issue.current <= pick;   // frozen once the load is issued
    end

    assign issue.ld_rdy = (|issue.ready_mask) && !issue.busy;

endmodule

/* verilog/lq_entries.sv */
`timescale 1ns/1ps
`include "lq_settings.svh"

module lq_entries (
    input logic clk,
    input logic rst,
    input lq_pkg::lq_mask_t insert,
    input lq_pkg::lq_tag_t [`LQ_DEPTH-1:0] insert_tag,
    input logic mem_rd,
    input logic [`LQ_TAG_W-2:0] upd_tag,
    input lq_pkg::lq_addr_t upd_addr,
    input lq_pkg::lq_preg_t upd_preg,
    input lq_pkg::lq_ptr_t cmmt_ptr,
    input logic flsh,
    input lq_pkg::lq_ptr_t mis_pred_ptr,
    input lq_pkg::lq_ptr_t tail,
    lq_issue_if.entries issue,
    output lq_pkg::lq_ptr_t head,
    output logic tail_free,
    output lq_pkg::lq_entry_t cur_entry
);
    import lq_pkg::*;

    lq_mask_t free_q;
    lq_mask_t rdy_q;
    lq_mask_t done_q;
    lq_tag_t tag_q [`LQ_DEPTH];
    lq_addr_t addr_q [`LQ_DEPTH];
    lq_preg_t preg_q [`LQ_DEPTH];

    lq_mask_t upd_m;
    lq_mask_t commit_m;
    lq_mask_t flush_m;
    lq_mask_t cur_hit;

    always_comb begin
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            upd_m[i] = mem_rd && !free_q[i] && (tag_q[i][`LQ_TAG_W-2:0] == upd_tag);
            cur_hit[i] = (issue.current == lq_ptr_t'(i));
        end
    end

    assign commit_m = lq_range_mask(head, cmmt_ptr);
    assign flush_m = flsh ? lq_range_mask(mis_pred_ptr, tail) : '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            head <= '0;
        else
            head <= cmmt_ptr;   // head tracks the commit pointer
    end

    // status bits: flush, then commit, then insert
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            free_q <= '1;
            rdy_q <= '0;
            done_q <= '0;
        end else begin
            for (int i = 0; i < `LQ_DEPTH; i++) begin
                if (flush_m[i] || commit_m[i]) begin
                    free_q[i] <= 1'b1;
                    rdy_q[i] <= 1'b0;
                    done_q[i] <= 1'b0;
                end else if (insert[i]) begin
                    free_q[i] <= 1'b0;
                    rdy_q[i] <= 1'b0;
                    done_q[i] <= 1'b0;
                end else begin
                    if (upd_m[i])
                        rdy_q[i] <= 1'b1;
                    if (issue.finished && cur_hit[i])
                        done_q[i] <= 1'b1;   // written back, never reissue
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            if (insert[i])
                tag_q[i] <= insert_tag[i];
            if (upd_m[i]) begin
                addr_q[i] <= upd_addr;
                preg_q[i] <= upd_preg;
            end
        end
    end

    assign issue.ready_mask = ~free_q & rdy_q & ~done_q;
    assign tail_free = free_q[tail];

    always_comb begin
        cur_entry.free = free_q[issue.current];
        cur_entry.addr_rdy = rdy_q[issue.current];
        cur_entry.done = done_q[issue.current];
        cur_entry.tag = tag_q[issue.current];
        cur_entry.addr = addr_q[issue.current];
        cur_entry.preg = preg_q[issue.current];
    end

endmodule

/* verilog/lq_alloc.sv */
`timescale 1ns/1ps
`include "lq_settings.svh"

module lq_alloc (
    input logic clk,
    input logic rst,
    input logic [`LQ_LANES-1:0] alloc_vld,
    input lq_pkg::lq_tag_t [`LQ_LANES-1:0] alloc_tag,
    input logic flsh,
    input lq_pkg::lq_ptr_t mis_pred_ptr,
    input logic tail_free,
    output lq_pkg::lq_ptr_t tail,
    output lq_pkg::lq_mask_t insert,
    output lq_pkg::lq_tag_t [`LQ_DEPTH-1:0] insert_tag,
    output logic stll
);
    import lq_pkg::*;

    localparam int CNT_W = $clog2(`LQ_LANES + 1);

    logic [CNT_W-1:0] cnt;            // contiguous valid lanes from lane 0
    logic [`LQ_LANES-1:0] lane_ok;
    logic run;
    lq_ptr_t pos;

    always_comb begin
        cnt = '0;
        run = 1'b1;
        for (int l = 0; l < `LQ_LANES; l++) begin
            run = run & alloc_vld[l];
            lane_ok[l] = run;
            cnt = cnt + {{(CNT_W-1){1'b0}}, run};
        end
    end

    // place counted lanes at tail, tail+1, ...
    always_comb begin
        insert = '0;
        insert_tag = '0;
        pos = tail;
        for (int l = 0; l < `LQ_LANES; l++) begin
            pos = lq_wrap_add(tail, lq_ptr_t'(l));
            if (lane_ok[l] && !flsh) begin
                insert[pos] = 1'b1;
                insert_tag[pos] = alloc_tag[l];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            tail <= '0;
        else if (flsh)
            tail <= mis_pred_ptr;   // drop everything past the mispredict
        else
            tail <= lq_wrap_add(tail, lq_ptr_t'(cnt));
    end

    assign stll = !tail_free;   // tail wrapped onto a live entry

endmodule

/* verilog/lq_issue_if.sv */
`timescale 1ns/1ps

interface lq_issue_if;
    import lq_pkg::*;

    lq_mask_t ready_mask;   // live, address known, not yet done
    logic busy;
    logic ld_rdy;
    lq_ptr_t current;       // entry being issued
    logic finished;

    modport entries (
        output ready_mask,
        input current,
        input finished
    );

    modport select (
        input ready_mask,
        input busy,
        output ld_rdy,
        output current
    );

    modport ctrl (
        input ld_rdy,
        output busy,
        output finished
    );

endinterface

/* verilog/lq_pkg.sv */
`include "lq_settings.svh"

package lq_pkg;

    typedef logic [`LQ_PTR_W-1:0] lq_ptr_t;
    typedef logic [`LQ_DEPTH-1:0] lq_mask_t;
    typedef logic [`LQ_TAG_W-1:0] lq_tag_t;
    typedef logic [`LQ_ADDR_W-1:0] lq_addr_t;
    typedef logic [`LQ_DATA_W-1:0] lq_data_t;
    typedef logic [`LQ_PREG_W-1:0] lq_preg_t;

    typedef struct packed {
        logic free;
        logic addr_rdy;
        logic done;
        lq_tag_t tag;
        lq_addr_t addr;
        lq_preg_t preg;
    } lq_entry_t;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        WAIT      = 3'd1,   // requesting, no grant yet
        ISSUED    = 3'd2,
        MEM_RDY   = 3'd3,   // cache data in, store queue pending
        FWD_RDY   = 3'd4,   // store queue in, cache pending
        BOTH_RDY  = 3'd5,
        WRITEBACK = 3'd6
    } lq_state_e;

    // pointer plus offset, modulo queue depth
    function automatic lq_ptr_t lq_wrap_add(lq_ptr_t base, lq_ptr_t offs);
        logic [`LQ_PTR_W:0] sum;
        sum = {1'b0, base} + {1'b0, offs};
        if (sum >= (`LQ_PTR_W+1)'(`LQ_DEPTH))
            sum = sum - (`LQ_PTR_W+1)'(`LQ_DEPTH);
        return sum[`LQ_PTR_W-1:0];
    endfunction

    // entries from first up to but not including last, wrapping
    function automatic lq_mask_t lq_range_mask(lq_ptr_t first, lq_ptr_t last);
        lq_mask_t m;
        m = '0;
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            if (first <= last)
                m[i] = (lq_ptr_t'(i) >= first) && (lq_ptr_t'(i) < last);
            else
                m[i] = (lq_ptr_t'(i) >= first) || (lq_ptr_t'(i) < last);
        end
        return m;
    endfunction

endpackage

/* include/lq_settings.svh */
`ifndef LQ_SETTINGS_SVH
`define LQ_SETTINGS_SVH

// queue geometry
`define LQ_DEPTH 24
`define LQ_PTR_W 5
`define LQ_LANES 4   // loads allocated per cycle

// field widths
`define LQ_TAG_W 7   // forwarding index, low bits are the load tag
`define LQ_ADDR_W 16
`define LQ_DATA_W 16
`define LQ_PREG_W 6

`endif
